// File: fetchStage1.f
+incdir+.
fetchPkg.sv
predictPkg.sv
branchTargetBuffer.sv
bimodalPredictor.sv
returnAddrStack.sv
pcGen.sv
fetchStage1.sv
fetchStage1_chk.sv
fetchStage1_tb.sv

// File: Makefile
# Verilator build and run of the fetch stage testbench

VERILATOR ?= verilator
TOP       ?= fetchStage1_tb
FILELIST  ?= fetchStage1.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Simulation finished: PASS

SRCS := $(shell grep -v '^+' $(FILELIST)) fetchStage1_defines.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: fetchStage1_tb.sv
`include "fetchStage1_defines.svh"

module fetchStage1_tb;

  import fetchPkg::*;
  import predictPkg::*;

  localparam int numCycles = 4000;

  logic     clk;
  logic     reset;
  pcT       startPC;
  logic     stall;
  logic     recoverFlag;
  pcT       recoverPC;
  logic     updateEn;
  pcT       updatePC;
  pcT       updateNPC;
  ctrlTypeT updateBrType;
  logic     updateDir;
  counterT  updateCounter;
  instT     inst [0:`FETCH_WIDTH-1];
  logic     instValid;
  logic     fetchReq;
  pcT       instPC [0:`FETCH_WIDTH-1];
  logic     fs1Ready;
  pcT       addrRAS;
  logic     pktValid    [0:`FETCH_WIDTH-1];
  pcT       pktPc       [0:`FETCH_WIDTH-1];
  instT     pktInst     [0:`FETCH_WIDTH-1];
  logic     pktBtbHit   [0:`FETCH_WIDTH-1];
  ctrlTypeT pktCtrlType [0:`FETCH_WIDTH-1];
  pcT       pktTakenPc  [0:`FETCH_WIDTH-1];
  logic     pktPredDir  [0:`FETCH_WIDTH-1];
  counterT  predCounter [0:`FETCH_WIDTH-1];

  // reference state of pc, btb, counters and stack
  pcT       mPc;
  logic     mBtbValid  [0:`BTB_ENTRIES-1];
  pcT       mBtbPc     [0:`BTB_ENTRIES-1];
  ctrlTypeT mBtbType   [0:`BTB_ENTRIES-1];
  pcT       mBtbTarget [0:`BTB_ENTRIES-1];
  counterT  mCnt       [0:`BP_ENTRIES-1];
  pcT       mRas       [0:`RAS_DEPTH-1];
  rasPtrT   mTop;

  // redirect kinds seen during the random run
  int retSeen;
  int callSeen;
  int condSeen;

  logic [31:0] lfsrState = 32'h3533;

  fetchStage1 fetchStage1_inst (
    .clk(clk), .reset(reset), .startPC_i(startPC),
    .stall_i(stall), .recoverFlag_i(recoverFlag), .recoverPC_i(recoverPC),
    .updateEn_i(updateEn), .updatePC_i(updatePC), .updateNPC_i(updateNPC),
    .updateBrType_i(updateBrType), .updateDir_i(updateDir),
    .updateCounter_i(updateCounter), .inst_i(inst), .instValid_i(instValid),
    .fetchReq_o(fetchReq), .instPC_o(instPC), .fs1Ready_o(fs1Ready),
    .addrRAS_o(addrRAS), .pktValid_o(pktValid), .pktPc_o(pktPc),
    .pktInst_o(pktInst), .pktBtbHit_o(pktBtbHit), .pktCtrlType_o(pktCtrlType),
    .pktTakenPc_o(pktTakenPc), .pktPredDir_o(pktPredDir),
    .predCounter_o(predCounter)
  );

  bind fetchStage1 fetchStage1Chk chkInst (
    .clk(clk), .reset(reset), .fetchReq_i(fetchReq_o), .instValid_i(instValid_i),
    .fs1Ready_i(fs1Ready_o), .instPC_i(instPC_o)
  );

  // instruction memory word mixes every address bit
  function automatic instT instWord(input pcT a);
    return {a[15:0], a[31:16]} ^ (a * 32'h9E37_79B1);
  endfunction

  for (genvar i = 0; i < `FETCH_WIDTH; i++)
  begin : gMem
    assign inst[i] = instWord(instPC[i]);
  end

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int k = 0; k < n; k++)
    begin
      val = {val[30:0], lfsrState[0]};
      lfsrState = lfsrStep(lfsrState);
    end
    return val;
  endfunction

  // saturating step toward the outcome
  function automatic counterT stepCounter(input counterT c, input logic dir);
    if (dir && c != 2'd3)
      return c + 2'd1;
    if (!dir && c != 2'd0)
      return c - 2'd1;
    return c;
  endfunction

  task automatic failRun();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic pcCheck(input string name, input pcT got, input pcT exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      failRun();
    end
  endtask

  task automatic instCheck(input string name, input instT got, input instT exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      failRun();
    end
  endtask

  task automatic typeCheck(input string name, input ctrlTypeT got, input ctrlTypeT exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
      failRun();
    end
  endtask

  task automatic counterCheck(input string name, input counterT got, input counterT exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      failRun();
    end
  endtask

  task automatic bitCheck(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      failRun();
    end
  endtask

  task automatic reportError(input string reason);
    $display("ERROR at %0t: %s", $time, reason);
    failRun();
  endtask

  // sites and targets share a 256-byte window so the btb aliases
  task automatic driveRandom();
    logic [31:0] r;
    stall         = (randBits(2) == 32'd3);
    recoverFlag   = (randBits(3) == 32'd7);
    r             = randBits(6);
    recoverPC     = 32'h0000_1000 + {r[29:0], 2'b00};
    instValid     = (randBits(2) != 32'd0);
    updateEn      = (randBits(1) == 32'd1);
    r             = randBits(5);
    updatePC      = 32'h0000_1000 + {r[29:0], 2'b00};
    r             = randBits(6);
    updateNPC     = 32'h0000_1000 + {r[29:0], 2'b00};
    r             = randBits(2);
    updateBrType  = ctrlTypeT'(r[1:0]);
    updateDir     = (randBits(1) == 32'd1);
    // in-order update carries the counter seen at prediction
    updateCounter = mCnt[updatePC[7:2]];
  endtask

  // compare one cycle against the model and then advance it
  task automatic modelCycle();
    pcT      lanePc [0:`FETCH_WIDTH-1];
    pcT      nextPc;
    btbIdxT  bi;
    counterT cnt;
    logic    valid;
    logic    hit;
    int      takenLane;
    valid     = instValid;
    takenLane = -1;
    bitCheck("fetchReq_o", fetchReq, 1'b1);
    bitCheck("fs1Ready_o", fs1Ready, valid);
    pcCheck("addrRAS_o", addrRAS, mRas[mTop]);
    for (int i = 0; i < `FETCH_WIDTH; i++)
    begin
      lanePc[i] = mPc + pcT'(i * `INST_BYTES);
      bi        = lanePc[i][5:2];
      hit       = mBtbValid[bi] && (mBtbPc[bi][31:6] == lanePc[i][31:6]);
      cnt       = mCnt[lanePc[i][7:2]];
      pcCheck($sformatf("instPC_o[%0d]", i), instPC[i], lanePc[i]);
      pcCheck($sformatf("pktPc_o[%0d]", i), pktPc[i], lanePc[i]);
      bitCheck($sformatf("pktValid_o[%0d]", i), pktValid[i], valid);
      instCheck($sformatf("pktInst_o[%0d]", i), pktInst[i], valid ? instWord(lanePc[i]) : '0);
      bitCheck($sformatf("pktBtbHit_o[%0d]", i), pktBtbHit[i], hit);
      bitCheck($sformatf("pktPredDir_o[%0d]", i), pktPredDir[i], cnt[1]);
      counterCheck($sformatf("predCounter_o[%0d]", i), predCounter[i], cnt);
      if (hit)
      begin
        typeCheck($sformatf("pktCtrlType_o[%0d]", i), pktCtrlType[i], mBtbType[bi]);
        pcCheck($sformatf("pktTakenPc_o[%0d]", i), pktTakenPc[i],
                (mBtbType[bi] == ret) ? mRas[mTop] : mBtbTarget[bi]);
        // lowest taken lane wins
        if (valid && takenLane < 0 && (cnt[1] || mBtbType[bi] != condBranch))
          takenLane = i;
      end
    end
    // next pc with recovery over stall over prediction
    if (recoverFlag)
      nextPc = recoverPC;
    else if (stall)
      nextPc = mPc;
    else if (takenLane >= 0)
    begin
      bi = lanePc[takenLane][5:2];
      if (mBtbType[bi] == ret)
      begin
        nextPc = mRas[mTop];
        mTop   = mTop - 1'b1;
        retSeen++;
      end
      else
      begin
        nextPc = mBtbTarget[bi];
        if (mBtbType[bi] == call)
        begin
          mTop       = mTop + 1'b1;
          mRas[mTop] = lanePc[takenLane] + pcT'(`INST_BYTES);
          callSeen++;
        end
        else if (mBtbType[bi] == condBranch)
          condSeen++;
      end
    end
    else
      nextPc = mPc + (valid ? pcT'(`INST_BYTES * `FETCH_WIDTH) : '0);
    // update port trains the tables even under stall
    if (updateEn)
    begin
      if (updateDir)
      begin
        bi             = updatePC[5:2];
        mBtbValid[bi]  = 1'b1;
        mBtbPc[bi]     = updatePC;
        mBtbType[bi]   = updateBrType;
        mBtbTarget[bi] = updateNPC;
      end
      if (updateBrType == condBranch)
        mCnt[updatePC[7:2]] = stepCounter(updateCounter, updateDir);
    end
    mPc = nextPc;
  endtask

  initial
  begin
    int waitCycles;
    reset         = 1'b1;
    startPC       = 32'h0000_1000;
    stall         = 1'b0;
    recoverFlag   = 1'b0;
    recoverPC     = '0;
    updateEn      = 1'b0;
    updatePC      = '0;
    updateNPC     = '0;
    updateBrType  = condBranch;
    updateDir     = 1'b0;
    updateCounter = 2'd1;
    instValid     = 1'b0;
    mPc           = startPC;
    mTop          = '0;
    retSeen       = 0;
    callSeen      = 0;
    condSeen      = 0;
    for (int j = 0; j < `BTB_ENTRIES; j++)
      mBtbValid[j] = 1'b0;
    for (int j = 0; j < `BP_ENTRIES; j++)
      mCnt[j] = 2'd1;
    for (int j = 0; j < `RAS_DEPTH; j++)
      mRas[j] = '0;

    // reset holds the request low and the pc at the start address
    repeat (15)
    begin
      @(posedge clk);
      #3;
      bitCheck("fetchReq_o", fetchReq, 1'b0);
      pcCheck("instPC_o[0]", instPC[0], startPC);
    end
    @(posedge clk);
    #1;
    reset = 1'b0;

    // request must rise at the first edge after release
    waitCycles = 0;
    while (fetchReq !== 1'b1)
    begin
      @(posedge clk);
      #3;
      waitCycles++;
      if (waitCycles > 8)
        reportError("fetch request never rose after reset");
    end
    if (waitCycles != 1)
      reportError("fetch request did not rise at the first edge after reset");
    pcCheck("instPC_o[0]", instPC[0], startPC);

    for (int c = 0; c < numCycles; c++)
    begin
      @(posedge clk);
      #1;
      driveRandom();
      #2;
      if (fetchStage1_inst.chkInst.failCount != 0)
        reportError("a bound assertion failed");
      modelCycle();
    end

    if (retSeen == 0 || callSeen == 0 || condSeen == 0)
    begin
      reportError("the run took no ret, no call or no cond redirect");
    end
    else
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

// File: fetchStage1_chk.sv
`include "fetchStage1_defines.svh"

module fetchStage1Chk (
  input  logic         clk,
  input  logic         reset,
  input  logic         fetchReq_i,
  input  logic         instValid_i,
  input  logic         fs1Ready_i,
  input  fetchPkg::pcT instPC_i [0:`FETCH_WIDTH-1]
);

  import fetchPkg::*;

  // bumped by every failing property, read by the testbench
  int unsigned failCount = 0;

  // no request may leave the stage while reset is held
  reqLowInReset : assert property (@(posedge clk) reset |-> !fetchReq_i)
  else
  begin
    $error("fetch request high during reset");
    failCount++;
  end

  // bundle ready is the lane-0 valid bit
  readyIsLaneValid : assert property (@(posedge clk) disable iff (reset)
    fs1Ready_i == (fetchReq_i & instValid_i))
  else
  begin
    $error("fs1Ready_o differs from lane-0 validity");
    failCount++;
  end

  // lane 1 sits one instruction after lane 0
  laneStride : assert property (@(posedge clk) disable iff (reset)
    instPC_i[1] == instPC_i[0] + pcT'(`INST_BYTES))
  else
  begin
    $error("lane 1 address is not lane 0 plus one instruction");
    failCount++;
  end

endmodule

// File: fetchStage1.sv
`include "fetchStage1_defines.svh"

module fetchStage1 (
  input  logic                 clk,
  input  logic                 reset,
  input  fetchPkg::pcT         startPC_i,

  input  logic                 stall_i,
  input  logic                 recoverFlag_i,
  input  fetchPkg::pcT         recoverPC_i,

  // in-order training from the branch queue
  input  logic                 updateEn_i,
  input  fetchPkg::pcT         updatePC_i,
  input  fetchPkg::pcT         updateNPC_i,
  input  predictPkg::ctrlTypeT updateBrType_i,
  input  logic                 updateDir_i,
  input  predictPkg::counterT  updateCounter_i,

  // raw instruction port
  input  fetchPkg::instT       inst_i [0:`FETCH_WIDTH-1],
  input  logic                 instValid_i,
  output logic                 fetchReq_o,
  output fetchPkg::pcT         instPC_o [0:`FETCH_WIDTH-1],

  output logic                 fs1Ready_o,
  output fetchPkg::pcT         addrRAS_o,

  // per-lane packets to the next stage
  output logic                 pktValid_o    [0:`FETCH_WIDTH-1],
  output fetchPkg::pcT         pktPc_o       [0:`FETCH_WIDTH-1],
  output fetchPkg::instT       pktInst_o     [0:`FETCH_WIDTH-1],
  output logic                 pktBtbHit_o   [0:`FETCH_WIDTH-1],
  output predictPkg::ctrlTypeT pktCtrlType_o [0:`FETCH_WIDTH-1],
  output fetchPkg::pcT         pktTakenPc_o  [0:`FETCH_WIDTH-1],
  output logic                 pktPredDir_o  [0:`FETCH_WIDTH-1],
  output predictPkg::counterT  predCounter_o [0:`FETCH_WIDTH-1]
);

  import fetchPkg::*;
  import predictPkg::*;

  pcT       lanePc      [0:`FETCH_WIDTH-1];
  logic     laneValid   [0:`FETCH_WIDTH-1];
  logic     btbHit      [0:`FETCH_WIDTH-1];
  ctrlTypeT btbCtrlType [0:`FETCH_WIDTH-1];
  pcT       btbTarget   [0:`FETCH_WIDTH-1];
  logic     predDir     [0:`FETCH_WIDTH-1];

  logic     rasPush;
  logic     rasPop;
  pcT       rasPushAddr;
  pcT       rasTop;

  logic     updateBtb;
  logic     updateBp;

  // btb only learns taken outcomes
  assign updateBtb = updateEn_i & updateDir_i;
  // counters only train on conditional branches
  assign updateBp  = updateEn_i & (updateBrType_i == condBranch);

  pcGen pcGenInst (
    .clk           (clk),
    .reset         (reset),
    .startPC_i     (startPC_i),
    .stall_i       (stall_i),
    .recoverFlag_i (recoverFlag_i),
    .recoverPC_i   (recoverPC_i),
    .instValid_i   (instValid_i),
    .btbHit_i      (btbHit),
    .btbCtrlType_i (btbCtrlType),
    .btbTarget_i   (btbTarget),
    .predDir_i     (predDir),
    .rasTop_i      (rasTop),
    .lanePc_o      (lanePc),
    .laneValid_o   (laneValid),
    .fetchReq_o    (fetchReq_o),
    .rasPush_o     (rasPush),
    .rasPop_o      (rasPop),
    .rasPushAddr_o (rasPushAddr)
  );

  branchTargetBuffer btbInst (
    .clk            (clk),
    .reset          (reset),
    .lanePc_i       (lanePc),
    .updateEn_i     (updateBtb),
    .updatePc_i     (updatePC_i),
    .updateNpc_i    (updateNPC_i),
    .updateBrType_i (updateBrType_i),
    .hit_o          (btbHit),
    .ctrlType_o     (btbCtrlType),
    .target_o       (btbTarget)
  );

  bimodalPredictor bpInst (
    .clk             (clk),
    .reset           (reset),
    .lanePc_i        (lanePc),
    .updateEn_i      (updateBp),
    .updatePc_i      (updatePC_i),
    .updateDir_i     (updateDir_i),
    .updateCounter_i (updateCounter_i),
    .predDir_o       (predDir),
    .predCounter_o   (predCounter_o)
  );

  returnAddrStack rasInst (
    .clk        (clk),
    .reset      (reset),
    .push_i     (rasPush),
    .pop_i      (rasPop),
    .pushAddr_i (rasPushAddr),
    .top_o      (rasTop)
  );

  // packet fields, same cycle as the fetch
  for (genvar i = 0; i < `FETCH_WIDTH; i++)
  begin : gPkt
    assign pktValid_o[i]    = laneValid[i];
    assign pktPc_o[i]       = lanePc[i];
    // zero word on a dead lane
    assign pktInst_o[i]     = laneValid[i] ? inst_i[i] : '0;
    assign pktBtbHit_o[i]   = btbHit[i];
    assign pktCtrlType_o[i] = btbCtrlType[i];
    // returns carry the stack top as their target
    assign pktTakenPc_o[i]  = (btbCtrlType[i] == ret) ? rasTop : btbTarget[i];
    assign pktPredDir_o[i]  = predDir[i];
  end

  assign instPC_o   = lanePc;
  // bundle valid follows lane 0
  assign fs1Ready_o = laneValid[0];
  assign addrRAS_o  = rasTop;

endmodule

// File: pcGen.sv
`include "fetchStage1_defines.svh"

module pcGen (
  input  logic                 clk,
  input  logic                 reset,
  input  fetchPkg::pcT         startPC_i,

  // back-pressure and recovery from later stages
  input  logic                 stall_i,
  input  logic                 recoverFlag_i,
  input  fetchPkg::pcT         recoverPC_i,

  // answer from the instruction port, same cycle
  input  logic                 instValid_i,

  // per-lane prediction inputs
  input  logic                 btbHit_i      [0:`FETCH_WIDTH-1],
  input  predictPkg::ctrlTypeT btbCtrlType_i [0:`FETCH_WIDTH-1],
  input  fetchPkg::pcT         btbTarget_i   [0:`FETCH_WIDTH-1],
  input  logic                 predDir_i     [0:`FETCH_WIDTH-1],

  input  fetchPkg::pcT         rasTop_i,

  output fetchPkg::pcT         lanePc_o    [0:`FETCH_WIDTH-1],
  output logic                 laneValid_o [0:`FETCH_WIDTH-1],
  output logic                 fetchReq_o,

  output logic                 rasPush_o,
  output logic                 rasPop_o,
  output fetchPkg::pcT         rasPushAddr_o
);

  import fetchPkg::*;
  import predictPkg::*;

  pcT   pc;
  pcT   nextPc;
  pcT   predNpc;

  logic takenVec [0:`FETCH_WIDTH-1];
  logic [$clog2(`FETCH_WIDTH+1)-1:0] numValid;

  // kind of the lowest taken lane
  logic callTaken;
  logic retTaken;

  // lanes follow lane 0 in sequence
  // all valid or none, the port answers the whole bundle
  for (genvar i = 0; i < `FETCH_WIDTH; i++)
  begin : gLane
    assign lanePc_o[i]    = pc + pcT'(i * `INST_BYTES);
    assign laneValid_o[i] = fetchReq_o & instValid_i;

    // btb hit that is unconditional or predicted taken
    assign takenVec[i] = laneValid_o[i] & btbHit_i[i] &
                         (predDir_i[i] | (btbCtrlType_i[i] != condBranch));
  end

  always_comb
  begin
    numValid = '0;
    for (int i = 0; i < `FETCH_WIDTH; i++)
    begin
      numValid = numValid + laneValid_o[i];
    end
  end

  // priority search, scanned high to low so the lowest taken lane wins
  // sequential advance when nothing is taken, zero lanes means hold
  always_comb
  begin
    predNpc   = pc + pcT'(numValid * `INST_BYTES);
    callTaken = 1'b0;
    retTaken  = 1'b0;
    rasPushAddr_o = lanePc_o[0] + pcT'(`INST_BYTES);
    for (int i = `FETCH_WIDTH-1; i >= 0; i--)
    begin
      if (takenVec[i])
      begin
        callTaken = 1'b0;
        retTaken  = 1'b0;
        if (btbCtrlType_i[i] == ret)
        begin
          // return target comes off the stack
          predNpc  = rasTop_i;
          retTaken = 1'b1;
        end
        else
        begin
          predNpc = btbTarget_i[i];
          if (btbCtrlType_i[i] == call)
          begin
            // return point is the slot after the call
            callTaken     = 1'b1;
            rasPushAddr_o = lanePc_o[i] + pcT'(`INST_BYTES);
          end
        end
      end
    end
  end

  // stack only moves when the prediction is actually followed
  assign rasPush_o = callTaken & ~stall_i & ~recoverFlag_i;
  assign rasPop_o  = retTaken & ~stall_i & ~recoverFlag_i;

  // recovery first, then stall hold, then prediction
  always_comb
  begin
    if (recoverFlag_i)
    begin
      nextPc = recoverPC_i;
    end
    else if (stall_i)
    begin
      nextPc = pc;
    end
    else
    begin
      nextPc = predNpc;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      pc <= startPC_i;
    end
    else
    begin
      pc <= nextPc;
    end
  end

  // request comes up one edge after reset release
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fetchReq_o <= 1'b0;
    end
    else
    begin
      fetchReq_o <= 1'b1;
    end
  end

endmodule

// File: returnAddrStack.sv
`include "fetchStage1_defines.svh"

module returnAddrStack (
  input  logic         clk,
  input  logic         reset,

  // at most one of push and pop per cycle
  input  logic         push_i,
  input  logic         pop_i,
  input  fetchPkg::pcT pushAddr_i,

  // current top of stack, combinational
  output fetchPkg::pcT top_o
);

  import fetchPkg::*;
  import predictPkg::*;

  // circular storage, oldest entry lost on overflow
  pcT     stackMem [0:`RAS_DEPTH-1];

  // points at the live top entry
  rasPtrT topPtr;
  rasPtrT pushPtr;
  rasPtrT popPtr;

  // both wrap through the pointer width
  assign pushPtr = topPtr + 1'b1;
  assign popPtr  = topPtr - 1'b1;

  // pointer moves on push and pop
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      topPtr <= '0;
    end
    else if (push_i)
    begin
      topPtr <= pushPtr;
    end
    else if (pop_i)
    begin
      topPtr <= popPtr;
    end
  end

  // entries start at zero
  // a push writes one slot above the old top
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int j = 0; j < `RAS_DEPTH; j++)
      begin
        stackMem[j] <= '0;
      end
    end
    else if (push_i)
    begin
      stackMem[pushPtr] <= pushAddr_i;
    end
  end

  // pop leaves the slot in place, only the pointer drops
  assign top_o = stackMem[topPtr];

endmodule

// File: bimodalPredictor.sv
`include "fetchStage1_defines.svh"

module bimodalPredictor (
  input  logic               clk,
  input  logic               reset,

  // one read per fetch lane
  input  fetchPkg::pcT       lanePc_i [0:`FETCH_WIDTH-1],

  // training, only for conditional branches
  input  logic               updateEn_i,
  input  fetchPkg::pcT       updatePc_i,
  input  logic               updateDir_i,
  input  predictPkg::counterT updateCounter_i,

  output logic               predDir_o     [0:`FETCH_WIDTH-1],
  output predictPkg::counterT predCounter_o [0:`FETCH_WIDTH-1]
);

  import predictPkg::*;

  // counter table
  counterT cntMem [0:`BP_ENTRIES-1];

  bpIdxT   updIdx;
  counterT nextCnt;

  assign updIdx = updatePc_i[`BP_ENTRIES_LOG+1:2];

  // step the counter seen at prediction time toward the outcome
  // saturates at 0 and 3
  always_comb
  begin
    nextCnt = updateCounter_i;
    if (updateDir_i && (updateCounter_i != 2'b11))
    begin
      nextCnt = updateCounter_i + 2'b01;
    end
    else if (!updateDir_i && (updateCounter_i != 2'b00))
    begin
      nextCnt = updateCounter_i - 2'b01;
    end
  end

  // all entries start weakly not-taken
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int j = 0; j < `BP_ENTRIES; j++)
      begin
        cntMem[j] <= 2'b01;
      end
    end
    else if (updateEn_i)
    begin
      cntMem[updIdx] <= nextCnt;
    end
  end

  // msb of the counter gives the direction
  for (genvar i = 0; i < `FETCH_WIDTH; i++)
  begin : gLane
    assign predCounter_o[i] = cntMem[lanePc_i[i][`BP_ENTRIES_LOG+1:2]];
    assign predDir_o[i]     = predCounter_o[i][1];
  end

endmodule

// File: branchTargetBuffer.sv
`include "fetchStage1_defines.svh"

module branchTargetBuffer (
  input  logic                 clk,
  input  logic                 reset,

  // one lookup per fetch lane
  input  fetchPkg::pcT         lanePc_i [0:`FETCH_WIDTH-1],

  // in-order training, already gated on taken direction
  input  logic                 updateEn_i,
  input  fetchPkg::pcT         updatePc_i,
  input  fetchPkg::pcT         updateNpc_i,
  input  predictPkg::ctrlTypeT updateBrType_i,

  output logic                 hit_o      [0:`FETCH_WIDTH-1],
  output predictPkg::ctrlTypeT ctrlType_o [0:`FETCH_WIDTH-1],
  output fetchPkg::pcT         target_o   [0:`FETCH_WIDTH-1]
);

  import fetchPkg::*;
  import predictPkg::*;

  // per-entry valid, only state that needs a reset
  logic [`BTB_ENTRIES-1:0] validVec;

  // entry payload
  btbTagT   tagMem    [0:`BTB_ENTRIES-1];
  ctrlTypeT typeMem   [0:`BTB_ENTRIES-1];
  pcT       targetMem [0:`BTB_ENTRIES-1];

  // update address split
  btbIdxT updIdx;
  btbTagT updTag;

  // lookup address split per lane
  btbIdxT laneIdx [0:`FETCH_WIDTH-1];
  btbTagT laneTag [0:`FETCH_WIDTH-1];

  // byte offset bits dropped
  assign updIdx = updatePc_i[`BTB_ENTRIES_LOG+1:2];
  assign updTag = updatePc_i[`PC_WIDTH-1:`BTB_ENTRIES_LOG+2];

  // valid bits, set on any update of the entry
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      validVec <= '0;
    end
    else if (updateEn_i)
    begin
      validVec[updIdx] <= 1'b1;
    end
  end

  // whole entry rewritten, tag type and target together
  always_ff @(posedge clk)
  begin
    if (updateEn_i)
    begin
      tagMem[updIdx]    <= updTag;
      typeMem[updIdx]   <= updateBrType_i;
      targetMem[updIdx] <= updateNpc_i;
    end
  end

  // combinational read, new entry seen from next cycle
  for (genvar i = 0; i < `FETCH_WIDTH; i++)
  begin : gLane
    assign laneIdx[i] = lanePc_i[i][`BTB_ENTRIES_LOG+1:2];
    assign laneTag[i] = lanePc_i[i][`PC_WIDTH-1:`BTB_ENTRIES_LOG+2];

    // hit needs a live entry and a full tag match
    assign hit_o[i]      = validVec[laneIdx[i]] & (tagMem[laneIdx[i]] == laneTag[i]);
    assign ctrlType_o[i] = typeMem[laneIdx[i]];
    assign target_o[i]   = targetMem[laneIdx[i]];
  end

endmodule

// File: predictPkg.sv
`include "fetchStage1_defines.svh"

package predictPkg;

  // control-transfer kind stored in the btb
  // condBranch is the only kind that consults the counters
  typedef enum logic [1:0] {
    ret        = 2'b00,
    call       = 2'b01,
    jump       = 2'b10,
    condBranch = 2'b11
  } ctrlTypeT;

  // two-bit saturating counter, msb is the direction
  typedef logic [1:0] counterT;

  // btb set index, pc bits above the byte offset
  typedef logic [`BTB_ENTRIES_LOG-1:0] btbIdxT;

  // btb tag, everything above index and byte offset
  typedef logic [`PC_WIDTH-`BTB_ENTRIES_LOG-3:0] btbTagT;

  // counter table index
  typedef logic [`BP_ENTRIES_LOG-1:0] bpIdxT;

  // stack pointer, wraps on overflow
  typedef logic [`RAS_DEPTH_LOG-1:0] rasPtrT;

endpackage

// File: fetchPkg.sv
`include "fetchStage1_defines.svh"

package fetchPkg;

  // byte address of an instruction
  // low two bits are always zero on the fetch path
  typedef logic [`PC_WIDTH-1:0] pcT;

  // one raw instruction word as returned by the fetch port
  typedef logic [`INST_WIDTH-1:0] instT;

endpackage

// File: fetchStage1_defines.svh
`ifndef FETCH_STAGE1_DEFINES_SVH
`define FETCH_STAGE1_DEFINES_SVH

// byte address width of the fetch PC
`define PC_WIDTH 32

// raw instruction word
`define INST_WIDTH 32

// bytes covered by one instruction
`define INST_BYTES 4

// lanes fetched per cycle, all sequential
`define FETCH_WIDTH 2

// direct-mapped target buffer
`define BTB_ENTRIES 16
`define BTB_ENTRIES_LOG 4

// bimodal two-bit counter table
`define BP_ENTRIES 64
`define BP_ENTRIES_LOG 6

// return address stack, circular
`define RAS_DEPTH 8
`define RAS_DEPTH_LOG 3

`endif
